/* design/cache_pkg.sv */
package cache_pkg;

    // address and data widths
    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;
    localparam int BLOCK_WIDTH = 64;
    localparam int BLOCK_BYTES = BLOCK_WIDTH / 8;

    // cache geometry
    localparam int N_SETS = 64;
    localparam int N_WAYS = 2;
    localparam int N_OFFSET_BITS = 3;
    localparam int N_INDEX_BITS = 6;
    localparam int N_TAG_BITS = ADDR_WIDTH - N_INDEX_BITS - N_OFFSET_BITS;
    localparam int BLOCK_ADDR_WIDTH = ADDR_WIDTH - N_OFFSET_BITS;   // tag and index

    // one row per set, way 1 in the upper half of each row
    localparam int TAG_ENTRY_WIDTH = N_WAYS * (N_TAG_BITS + 1);    // valid + tag per way
    localparam int DATA_ROW_WIDTH = N_WAYS * BLOCK_WIDTH;

    // replacement lfsr, x^8 + x^6 + x^5 + x^4 + 1
    localparam logic [7:0] LFSR_SEED = 8'h01;
    localparam logic [7:0] LFSR_TAPS = 8'hB8;

    typedef enum logic {
        READ,
        WRITE
    } req_type_t;

    typedef enum logic [1:0] {
        BYTE,
        HALFWORD,
        WORD
    } req_width_t;

    typedef enum logic [1:0] {
        LOOKUP,         // compare tags of the row read last cycle
        REFILL,         // fetch the missing block
        WRITE_THROUGH,  // send the merged block to memory
        RESPOND         // reread after refill, or answer a store
    } cache_state_t;

endpackage

/* design/lfsr_8bit.sv */
module lfsr_8bit (
    input  logic clk,
    input  logic rst_aL,
    input  logic step,
    output logic out_bit
);

    logic [7:0] state;

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            state <= cache_pkg::LFSR_SEED;
        end else if (step) begin
            // galois form, shift right and fold the taps back in
            state <= {1'b0, state[7:1]} ^ (state[0] ? cache_pkg::LFSR_TAPS : 8'h00);
        end
    end

    assign out_bit = state[0];

    // the all-zero state would lock the generator up
    a_state_nonzero: assert property (@(posedge clk) disable iff (!rst_aL)
        state != 8'h00);

endmodule

/* design/sram_1rw.sv */
module sram_1rw #(
    parameter int DEPTH = 64,
    parameter int WIDTH = 48,
    parameter int WSIZE = 24
) (
    input  logic                     clk,
    input  logic                     rst_aL,
    input  logic                     ce,
    input  logic                     we,
    input  logic [WIDTH/WSIZE-1:0]   wmask,   // one bit per slice
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         din,
    output logic [WIDTH-1:0]         dout
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            // clearing every row leaves all valid bits at zero
            for (int r = 0; r < DEPTH; r++) begin
                mem[r] <= '0;
            end
            dout <= '0;
        end else if (ce) begin
            if (we) begin
                for (int s = 0; s < WIDTH / WSIZE; s++) begin
                    if (wmask[s]) begin
                        mem[addr][s*WSIZE +: WSIZE] <= din[s*WSIZE +: WSIZE];
                    end
                end
            end else begin
                dout <= mem[addr];   // read data one cycle later
            end
        end
    end

endmodule

/* design/cache_ctrl.sv */
module cache_ctrl (
    input  logic                                     clk,
    input  logic                                     rst_aL,
    // pipeline
    input  logic                                     req_valid,
    input  cache_pkg::req_type_t                     req_type,
    input  cache_pkg::req_width_t                    req_width,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]         req_addr,
    input  logic [cache_pkg::WORD_WIDTH-1:0]         req_wr_data,
    output logic                                     resp_valid,
    output logic [cache_pkg::WORD_WIDTH-1:0]         resp_rd_data,
    // tag array
    output logic                                     tag_ce,
    output logic                                     tag_we,
    output logic [cache_pkg::N_WAYS-1:0]             tag_wmask,
    output logic [cache_pkg::N_INDEX_BITS-1:0]       tag_addr,
    output logic [cache_pkg::TAG_ENTRY_WIDTH-1:0]    tag_din,
    input  logic [cache_pkg::TAG_ENTRY_WIDTH-1:0]    tag_dout,
    // data array
    output logic                                     data_ce,
    output logic                                     data_we,
    output logic [cache_pkg::DATA_ROW_WIDTH/8-1:0]   data_wmask,
    output logic [cache_pkg::N_INDEX_BITS-1:0]       data_addr,
    output logic [cache_pkg::DATA_ROW_WIDTH-1:0]     data_din,
    input  logic [cache_pkg::DATA_ROW_WIDTH-1:0]     data_dout,
    // replacement
    input  logic                                     random_way,
    output logic                                     lfsr_step,
    // block bus
    output logic                                     blk_req_valid,
    output cache_pkg::req_type_t                     blk_req_type,
    output logic [cache_pkg::BLOCK_ADDR_WIDTH-1:0]   blk_req_addr,
    output logic [cache_pkg::BLOCK_WIDTH-1:0]        blk_req_data,
    input  logic                                     blk_req_ready,
    input  logic                                     blk_resp_valid,
    input  logic [cache_pkg::BLOCK_WIDTH-1:0]        blk_resp_data
);

    cache_pkg::cache_state_t state;
    logic active;     // a request has been taken and is not answered yet
    logic blk_sent;   // block request accepted, waiting for its response
    logic wt_done;
    logic victim;

    // latched request
    cache_pkg::req_type_t                   lat_type;
    cache_pkg::req_width_t                  lat_width;
    logic [cache_pkg::N_TAG_BITS-1:0]       lat_tag;
    logic [cache_pkg::N_INDEX_BITS-1:0]     lat_index;
    logic [cache_pkg::N_OFFSET_BITS-1:0]    lat_offset;
    logic [cache_pkg::WORD_WIDTH-1:0]       lat_wr_data;
    logic [cache_pkg::BLOCK_WIDTH-1:0]      wt_block;

    logic accept, lookup, store_hit, refill_wr, reread;
    logic way0_valid, way1_valid, way0_hit, way1_hit, hit;
    logic [cache_pkg::BLOCK_WIDTH-1:0] hit_block, store_block, merged;
    logic [cache_pkg::BLOCK_BYTES-1:0] byte_mask;

    assign accept = req_valid & ~active;
    assign lookup = (state == cache_pkg::LOOKUP) & active;

    // each way entry is {valid, tag}
    assign way0_valid = tag_dout[cache_pkg::N_TAG_BITS];
    assign way1_valid = tag_dout[cache_pkg::TAG_ENTRY_WIDTH-1];
    assign way0_hit = way0_valid & (tag_dout[cache_pkg::N_TAG_BITS-1:0] == lat_tag);
    assign way1_hit = way1_valid
                    & (tag_dout[cache_pkg::TAG_ENTRY_WIDTH-2 -: cache_pkg::N_TAG_BITS] == lat_tag);
    assign hit = way0_hit | way1_hit;

    assign hit_block = way1_hit ? data_dout[cache_pkg::DATA_ROW_WIDTH-1 -: cache_pkg::BLOCK_WIDTH]
                                : data_dout[cache_pkg::BLOCK_WIDTH-1:0];
    assign resp_rd_data = lat_offset[2] ? hit_block[cache_pkg::BLOCK_WIDTH-1 -: cache_pkg::WORD_WIDTH]
                                        : hit_block[cache_pkg::WORD_WIDTH-1:0];

    assign store_hit = lookup & hit & (lat_type == cache_pkg::WRITE);
    assign refill_wr = (state == cache_pkg::REFILL) & blk_resp_valid;
    assign reread = (state == cache_pkg::RESPOND) & ~wt_done;   // row changed, read it again

    assign resp_valid = (lookup & hit & (lat_type == cache_pkg::READ))
                      | ((state == cache_pkg::RESPOND) & wt_done);

    // store data replicated across the block, the byte mask picks the lanes
    always_comb begin
        case (lat_width)
            cache_pkg::BYTE: begin
                store_block = {cache_pkg::BLOCK_BYTES{lat_wr_data[7:0]}};
                byte_mask = 8'b0000_0001 << lat_offset;
            end
            cache_pkg::HALFWORD: begin
                store_block = {(cache_pkg::BLOCK_BYTES / 2){lat_wr_data[15:0]}};
                byte_mask = 8'b0000_0011 << lat_offset;
            end
            default: begin
                store_block = {(cache_pkg::BLOCK_WIDTH / cache_pkg::WORD_WIDTH){lat_wr_data}};
                byte_mask = 8'b0000_1111 << lat_offset;
            end
        endcase
    end

    always_comb begin
        for (int b = 0; b < cache_pkg::BLOCK_BYTES; b++) begin
            merged[8*b +: 8] = byte_mask[b] ? store_block[8*b +: 8] : hit_block[8*b +: 8];
        end
    end

    // arrays: read on accept, write on refill or store hit
    assign tag_ce = accept | refill_wr | reread;
    assign tag_we = refill_wr;
    assign tag_wmask = {victim, ~victim};
    assign tag_addr = accept ? req_addr[cache_pkg::N_OFFSET_BITS +: cache_pkg::N_INDEX_BITS]
                             : lat_index;
    assign tag_din = {1'b1, lat_tag, 1'b1, lat_tag};

    assign data_ce = tag_ce | store_hit;
    assign data_we = refill_wr | store_hit;
    assign data_addr = tag_addr;
    assign data_din = refill_wr ? {cache_pkg::N_WAYS{blk_resp_data}}
                                : {cache_pkg::N_WAYS{store_block}};
    assign data_wmask = refill_wr ? {{cache_pkg::BLOCK_BYTES{victim}}, {cache_pkg::BLOCK_BYTES{~victim}}}
                      : way1_hit  ? {byte_mask, {cache_pkg::BLOCK_BYTES{1'b0}}}
                                  : {{cache_pkg::BLOCK_BYTES{1'b0}}, byte_mask};

    assign lfsr_step = lookup & ~hit & way0_valid & way1_valid;   // random pick used

    assign blk_req_valid = ((state == cache_pkg::REFILL) | (state == cache_pkg::WRITE_THROUGH))
                         & ~blk_sent;
    assign blk_req_type = (state == cache_pkg::WRITE_THROUGH) ? cache_pkg::WRITE : cache_pkg::READ;
    assign blk_req_addr = {lat_tag, lat_index};
    assign blk_req_data = wt_block;

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            state <= cache_pkg::LOOKUP;
            active <= 1'b0;
            blk_sent <= 1'b0;
            wt_done <= 1'b0;
            victim <= 1'b0;
        end else begin
            if (blk_req_valid && blk_req_ready) begin
                blk_sent <= 1'b1;
            end else if (blk_resp_valid) begin
                blk_sent <= 1'b0;
            end
            case (state)
                cache_pkg::LOOKUP: begin
                    if (accept) begin
                        active <= 1'b1;
                    end else if (active) begin
                        if (!hit) begin
                            // invalid way first, way 0 before way 1
                            victim <= !way0_valid ? 1'b0 : (!way1_valid ? 1'b1 : random_way);
                            state <= cache_pkg::REFILL;
                        end else if (lat_type == cache_pkg::WRITE) begin
                            state <= cache_pkg::WRITE_THROUGH;
                        end else begin
                            active <= 1'b0;   // read hit answered this cycle
                        end
                    end
                end
                cache_pkg::REFILL: begin
                    if (blk_resp_valid) state <= cache_pkg::RESPOND;
                end
                cache_pkg::WRITE_THROUGH: begin
                    if (blk_resp_valid) begin
                        wt_done <= 1'b1;
                        state <= cache_pkg::RESPOND;
                    end
                end
                default: begin   // RESPOND
                    if (wt_done) begin
                        active <= 1'b0;
                        wt_done <= 1'b0;
                    end
                    state <= cache_pkg::LOOKUP;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lat_type <= req_type;
            lat_width <= req_width;
            {lat_tag, lat_index, lat_offset} <= req_addr;
            lat_wr_data <= req_wr_data;
        end
        if (store_hit) wt_block <= merged;   // block image after the store
    end

    // a block lives in at most one way of its set
    a_one_way_hit: assert property (@(posedge clk) disable iff (!rst_aL)
        lookup |-> !(way0_hit && way1_hit));

endmodule

/* design/wb_block_master.sv */
module wb_block_master (
    input  logic                                     clk,
    input  logic                                     rst_aL,
    // block side
    input  logic                                     blk_req_valid,
    input  cache_pkg::req_type_t                     blk_req_type,
    input  logic [cache_pkg::BLOCK_ADDR_WIDTH-1:0]   blk_req_addr,
    input  logic [cache_pkg::BLOCK_WIDTH-1:0]        blk_req_data,
    output logic                                     blk_req_ready,
    output logic                                     blk_resp_valid,
    output logic [cache_pkg::BLOCK_WIDTH-1:0]        blk_resp_data,
    // wishbone classic
    output logic                                     wb_cyc,
    output logic                                     wb_stb,
    output logic                                     wb_we,
    output logic [cache_pkg::ADDR_WIDTH-1:0]         wb_adr,
    output logic [cache_pkg::WORD_WIDTH-1:0]         wb_dat_o,
    output logic [cache_pkg::WORD_WIDTH/8-1:0]       wb_sel,
    input  logic [cache_pkg::WORD_WIDTH-1:0]         wb_dat_i,
    input  logic                                     wb_ack
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_BEAT,   // strobe up, waiting for ack
        M_GAP     // bus idle for one cycle between the beats
    } mstate_t;

    mstate_t mstate;
    logic beat;   // 0 = low word at the base address
    cache_pkg::req_type_t op;
    logic [cache_pkg::BLOCK_ADDR_WIDTH-1:0] blk_addr;
    logic [cache_pkg::BLOCK_WIDTH-1:0] wr_block;

    assign blk_req_ready = (mstate == M_IDLE);
    assign wb_we = (op == cache_pkg::WRITE);
    assign wb_adr = {blk_addr, beat, 2'b00};
    assign wb_dat_o = beat ? wr_block[cache_pkg::BLOCK_WIDTH-1 -: cache_pkg::WORD_WIDTH]
                           : wr_block[cache_pkg::WORD_WIDTH-1:0];
    assign wb_sel = '1;

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            mstate <= M_IDLE;
            beat <= 1'b0;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            blk_resp_valid <= 1'b0;
        end else begin
            blk_resp_valid <= 1'b0;   // one cycle pulse
            case (mstate)
                M_IDLE: begin
                    if (blk_req_valid) begin
                        beat <= 1'b0;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        mstate <= M_BEAT;
                    end
                end
                M_BEAT: begin
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        if (beat) begin
                            blk_resp_valid <= 1'b1;
                            mstate <= M_IDLE;
                        end else begin
                            beat <= 1'b1;
                            mstate <= M_GAP;
                        end
                    end
                end
                M_GAP: begin
                    wb_cyc <= 1'b1;
                    wb_stb <= 1'b1;
                    mstate <= M_BEAT;
                end
                default: mstate <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (blk_req_valid && blk_req_ready) begin
            op <= blk_req_type;
            blk_addr <= blk_req_addr;
            wr_block <= blk_req_data;
        end
        if (wb_stb && wb_ack && !wb_we) begin   // collect read beats
            if (beat) blk_resp_data[cache_pkg::BLOCK_WIDTH-1 -: cache_pkg::WORD_WIDTH] <= wb_dat_i;
            else blk_resp_data[cache_pkg::WORD_WIDTH-1:0] <= wb_dat_i;
        end
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_aL)
        wb_stb |-> wb_cyc);

    // classic cycle, master holds the beat until the slave acks
    a_hold_until_ack: assert property (@(posedge clk) disable iff (!rst_aL)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_o) && $stable(wb_we));

endmodule

/* design/dcache_top.sv */
module dcache_top (
    input  logic                                 clk,
    input  logic                                 rst_aL,
    // pipeline
    input  logic                                 req_valid,
    input  cache_pkg::req_type_t                 req_type,
    input  cache_pkg::req_width_t                req_width,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]     req_addr,
    input  logic [cache_pkg::WORD_WIDTH-1:0]     req_wr_data,
    output logic                                 resp_valid,
    output logic [cache_pkg::WORD_WIDTH-1:0]     resp_rd_data,
    // wishbone
    output logic                                 wb_cyc,
    output logic                                 wb_stb,
    output logic                                 wb_we,
    output logic [cache_pkg::ADDR_WIDTH-1:0]     wb_adr,
    output logic [cache_pkg::WORD_WIDTH-1:0]     wb_dat_o,
    output logic [cache_pkg::WORD_WIDTH/8-1:0]   wb_sel,
    input  logic [cache_pkg::WORD_WIDTH-1:0]     wb_dat_i,
    input  logic                                 wb_ack
);

    logic tag_ce, tag_we;
    logic [cache_pkg::N_WAYS-1:0] tag_wmask;
    logic [cache_pkg::N_INDEX_BITS-1:0] tag_addr, data_addr;
    logic [cache_pkg::TAG_ENTRY_WIDTH-1:0] tag_din, tag_dout;
    logic data_ce, data_we;
    logic [cache_pkg::DATA_ROW_WIDTH/8-1:0] data_wmask;
    logic [cache_pkg::DATA_ROW_WIDTH-1:0] data_din, data_dout;
    logic random_way, lfsr_step;
    logic blk_req_valid, blk_req_ready, blk_resp_valid;
    cache_pkg::req_type_t blk_req_type;
    logic [cache_pkg::BLOCK_ADDR_WIDTH-1:0] blk_req_addr;
    logic [cache_pkg::BLOCK_WIDTH-1:0] blk_req_data, blk_resp_data;

    cache_ctrl ctrl0 (
        .clk(clk), .rst_aL(rst_aL),
        .req_valid(req_valid), .req_type(req_type), .req_width(req_width),
        .req_addr(req_addr), .req_wr_data(req_wr_data),
        .resp_valid(resp_valid), .resp_rd_data(resp_rd_data),
        .tag_ce(tag_ce), .tag_we(tag_we), .tag_wmask(tag_wmask),
        .tag_addr(tag_addr), .tag_din(tag_din), .tag_dout(tag_dout),
        .data_ce(data_ce), .data_we(data_we), .data_wmask(data_wmask),
        .data_addr(data_addr), .data_din(data_din), .data_dout(data_dout),
        .random_way(random_way), .lfsr_step(lfsr_step),
        .blk_req_valid(blk_req_valid), .blk_req_type(blk_req_type),
        .blk_req_addr(blk_req_addr), .blk_req_data(blk_req_data),
        .blk_req_ready(blk_req_ready), .blk_resp_valid(blk_resp_valid),
        .blk_resp_data(blk_resp_data)
    );

    lfsr_8bit lfsr0 (
        .clk(clk), .rst_aL(rst_aL), .step(lfsr_step), .out_bit(random_way)
    );

    // one {valid, tag} slice per way
    sram_1rw #(
        .DEPTH(cache_pkg::N_SETS),
        .WIDTH(cache_pkg::TAG_ENTRY_WIDTH),
        .WSIZE(cache_pkg::TAG_ENTRY_WIDTH / cache_pkg::N_WAYS)
    ) tag_array (
        .clk(clk), .rst_aL(rst_aL), .ce(tag_ce), .we(tag_we), .wmask(tag_wmask),
        .addr(tag_addr), .din(tag_din), .dout(tag_dout)
    );

    // byte-writable, both ways in one row
    sram_1rw #(
        .DEPTH(cache_pkg::N_SETS),
        .WIDTH(cache_pkg::DATA_ROW_WIDTH),
        .WSIZE(8)
    ) data_array (
        .clk(clk), .rst_aL(rst_aL), .ce(data_ce), .we(data_we), .wmask(data_wmask),
        .addr(data_addr), .din(data_din), .dout(data_dout)
    );

    wb_block_master wbm0 (
        .clk(clk), .rst_aL(rst_aL),
        .blk_req_valid(blk_req_valid), .blk_req_type(blk_req_type),
        .blk_req_addr(blk_req_addr), .blk_req_data(blk_req_data),
        .blk_req_ready(blk_req_ready), .blk_resp_valid(blk_resp_valid),
        .blk_resp_data(blk_resp_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_sel(wb_sel), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

endmodule

/* verification/wb_mem_slave.sv */
module wb_mem_slave #(
    parameter int          WORDS    = 1024,          // 4 KB of word storage
    parameter logic [31:0] INIT_XOR = 32'h0000_0000,
    parameter logic [31:0] SEED     = 32'd97057
) (
    input  logic        clk,
    input  logic        rst_aL,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_i,    // write data from the master
    input  logic [3:0]  wb_sel,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack,
    input  logic [31:0] peek_adr,    // side port for the testbench compare
    output logic [31:0] peek_dat,
    output logic [31:0] beat_count
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int AW = $clog2(WORDS);

    logic [31:0] mem [WORDS];
    logic [31:0] lfsr, lfsr_a, lfsr_b;
    logic [1:0] wait_cnt;
    logic busy;
    logic [AW-1:0] idx;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    assign lfsr_a = lfsr_next(lfsr);    // one step per wait-state bit
    assign lfsr_b = lfsr_next(lfsr_a);
    assign idx = wb_adr[AW+1:2];
    assign peek_dat = mem[peek_adr[AW+1:2]];

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            // initial word is its own byte address folded with a constant
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= (i * 4) ^ INIT_XOR;
            end
            lfsr <= SEED;
            busy <= 1'b0;
            wait_cnt <= 2'd0;
            wb_ack <= 1'b0;
            wb_dat_o <= 32'h0;
            beat_count <= 32'h0;
        end else begin
            wb_ack <= 1'b0;   // ack is a single cycle
            if (busy) begin
                if (wait_cnt == 2'd0) begin
                    busy <= 1'b0;
                    wb_ack <= 1'b1;
                    beat_count <= beat_count + 32'd1;
                    if (wb_we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (wb_sel[b]) mem[idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
                        end
                    end else begin
                        wb_dat_o <= mem[idx];
                    end
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end else if (wb_cyc && wb_stb && !wb_ack) begin
                busy <= 1'b1;   // new beat, 0 to 3 wait states
                wait_cnt <= {lfsr_a[0], lfsr_b[0]};
                lfsr <= lfsr_b;
            end
        end
    end

endmodule

/* verification/tb_dcache.sv */
module tb_dcache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] INIT_XOR = 32'hC3A5_5A3C;
    localparam int MAX_ROWS = 32;
    localparam int ANY_BEATS = -1;        // hit or refill, depends on the random victim
    localparam int CYCLES_PER_ROW = 40;

    logic clk;
    logic rst_aL;
    logic req_valid;
    cache_pkg::req_type_t req_type;
    cache_pkg::req_width_t req_width;
    logic [cache_pkg::ADDR_WIDTH-1:0] req_addr;
    logic [cache_pkg::WORD_WIDTH-1:0] req_wr_data;
    logic resp_valid;
    logic [cache_pkg::WORD_WIDTH-1:0] resp_rd_data;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [31:0] wb_adr, wb_wr_dat, wb_rd_dat;
    logic [3:0] wb_sel;
    logic [31:0] peek_adr, peek_dat, beat_count;

    // stimulus and expected beats, one row per request
    string row_name [MAX_ROWS];
    cache_pkg::req_type_t row_type [MAX_ROWS];
    cache_pkg::req_width_t row_width [MAX_ROWS];
    logic [31:0] row_addr [MAX_ROWS];
    logic [31:0] row_data [MAX_ROWS];
    int row_beats [MAX_ROWS];
    int n_rows;

    logic [7:0] ref_mem [int unsigned];   // bytes written so far
    int cycle_count;
    int cycle_limit;

    dcache_top dut0 (
        .clk(clk), .rst_aL(rst_aL),
        .req_valid(req_valid), .req_type(req_type), .req_width(req_width),
        .req_addr(req_addr), .req_wr_data(req_wr_data),
        .resp_valid(resp_valid), .resp_rd_data(resp_rd_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_wr_dat), .wb_sel(wb_sel), .wb_dat_i(wb_rd_dat), .wb_ack(wb_ack)
    );

    wb_mem_slave #(.WORDS(1024), .INIT_XOR(INIT_XOR), .SEED(32'd97057)) mem0 (
        .clk(clk), .rst_aL(rst_aL),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_wr_dat), .wb_sel(wb_sel), .wb_dat_o(wb_rd_dat), .wb_ack(wb_ack),
        .peek_adr(peek_adr), .peek_dat(peek_dat), .beat_count(beat_count)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    // untouched memory holds A ^ INIT_XOR in the word at byte address A
    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        logic [31:0] w;
        if (ref_mem.exists(a)) return ref_mem[a];
        w = {a[31:2], 2'b00} ^ INIT_XOR;
        return w[8*a[1:0] +: 8];
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] a);
        return {ref_byte(a + 3), ref_byte(a + 2), ref_byte(a + 1), ref_byte(a)};
    endfunction

    task automatic apply_store(input logic [31:0] addr, input cache_pkg::req_width_t width,
                               input logic [31:0] data);
        int n;
        int k;
        case (width)
            cache_pkg::BYTE: n = 1;
            cache_pkg::HALFWORD: n = 2;
            default: n = 4;
        endcase
        for (k = 0; k < n; k++) begin
            ref_mem[addr + k] = data[8*k +: 8];   // little endian lanes
        end
    endtask

    task automatic add_row(input string name, input cache_pkg::req_type_t typ,
                           input cache_pkg::req_width_t width, input logic [31:0] addr,
                           input logic [31:0] data, input int beats);
        row_name[n_rows] = name;
        row_type[n_rows] = typ;
        row_width[n_rows] = width;
        row_addr[n_rows] = addr;
        row_data[n_rows] = data;
        row_beats[n_rows] = beats;
        n_rows++;
    endtask

    task automatic build_table();
        add_row("read_miss", cache_pkg::READ, cache_pkg::WORD, 32'h100, 32'h0, 2);
        add_row("read_hit_upper", cache_pkg::READ, cache_pkg::WORD, 32'h104, 32'h0, 0);
        add_row("store_word", cache_pkg::WRITE, cache_pkg::WORD, 32'h100, 32'h1234_5678, 2);
        add_row("store_byte", cache_pkg::WRITE, cache_pkg::BYTE, 32'h101, 32'h0000_00C7, 2);
        add_row("store_half", cache_pkg::WRITE, cache_pkg::HALFWORD, 32'h106, 32'h0000_BEEF, 2);
        add_row("read_merged_lo", cache_pkg::READ, cache_pkg::WORD, 32'h100, 32'h0, 0);
        add_row("read_merged_hi", cache_pkg::READ, cache_pkg::WORD, 32'h104, 32'h0, 0);
        add_row("store_miss", cache_pkg::WRITE, cache_pkg::WORD, 32'h208, 32'hCAFE_F00D, 4);
        add_row("read_store_miss", cache_pkg::READ, cache_pkg::WORD, 32'h208, 32'h0, 0);
        add_row("read_store_miss_hi", cache_pkg::READ, cache_pkg::WORD, 32'h20C, 32'h0, 0);
        // 0x100, 0x300 and 0x500 share set 32
        add_row("conflict_a", cache_pkg::READ, cache_pkg::WORD, 32'h300, 32'h0, 2);
        // the empty way took the new block, so the first one is still there
        add_row("read_first_kept", cache_pkg::READ, cache_pkg::WORD, 32'h104, 32'h0, 0);
        add_row("conflict_b", cache_pkg::READ, cache_pkg::WORD, 32'h504, 32'h0, 2);
        add_row("reread_first", cache_pkg::READ, cache_pkg::WORD, 32'h100, 32'h0, ANY_BEATS);
        add_row("reread_a", cache_pkg::READ, cache_pkg::WORD, 32'h304, 32'h0, ANY_BEATS);
        add_row("reread_b", cache_pkg::READ, cache_pkg::WORD, 32'h500, 32'h0, ANY_BEATS);
        add_row("reread_first_byte", cache_pkg::READ, cache_pkg::BYTE, 32'h103, 32'h0, ANY_BEATS);
        add_row("reread_a_half", cache_pkg::READ, cache_pkg::HALFWORD, 32'h302, 32'h0, ANY_BEATS);
        add_row("reread_b_upper", cache_pkg::READ, cache_pkg::WORD, 32'h504, 32'h0, ANY_BEATS);
    endtask

    task automatic run_row(input int i);
        logic [31:0] word_addr;
        logic [31:0] beats_before;
        int beats;
        int latency;
        word_addr = {row_addr[i][31:2], 2'b00};
        @(negedge clk);
        req_valid = 1'b1;
        req_type = row_type[i];
        req_width = row_width[i];
        req_addr = row_addr[i];
        req_wr_data = row_data[i];
        peek_adr = word_addr;
        beats_before = beat_count;
        @(negedge clk);
        latency = 1;
        while (!resp_valid) begin   // the cycle limit catches a lost response
            @(negedge clk);
            latency++;
        end
        beats = beat_count - beats_before;
        req_valid = 1'b0;
        if (row_type[i] == cache_pkg::WRITE) begin
            apply_store(row_addr[i], row_width[i], row_data[i]);
        end else begin
            check_value({row_name[i], " data"}, ref_word(word_addr), resp_rd_data);
        end
        if (row_beats[i] == ANY_BEATS) begin
            check_value({row_name[i], " beats"}, (beats == 0) ? 0 : 2, beats);
        end else begin
            check_value({row_name[i], " beats"}, row_beats[i], beats);
        end
        if (row_type[i] == cache_pkg::READ && beats == 0) begin
            check_value({row_name[i], " latency"}, 1, latency);   // hit answers next cycle
        end
        // write-through keeps memory equal to the reference
        check_value({row_name[i], " memory"}, ref_word(word_addr), peek_dat);
    endtask

    initial begin
        clk = 1'b0;
        rst_aL = 1'b0;
        req_valid = 1'b0;
        req_type = cache_pkg::READ;
        req_width = cache_pkg::WORD;
        req_addr = '0;
        req_wr_data = '0;
        peek_adr = 32'h0;
        cycle_count = 0;
        cycle_limit = 0;
        n_rows = 0;
        build_table();
        cycle_limit = n_rows * CYCLES_PER_ROW + 20;   // reset and idle check on top
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_aL = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_value("idle resp_valid", 32'h0, {31'b0, resp_valid});
            check_value("idle wb_cyc", 32'h0, {31'b0, wb_cyc});
            check_value("idle wb_stb", 32'h0, {31'b0, wb_stb});
        end
        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* vlog.f */
design/cache_pkg.sv
design/lfsr_8bit.sv
design/sram_1rw.sv
design/cache_ctrl.sv
design/wb_block_master.sv
design/dcache_top.sv
verification/wb_mem_slave.sv
verification/tb_dcache.sv

/* Makefile */
# Verilator build for the data cache testbench
# the simulator exits non-zero when the testbench stops with $fatal

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard design/*.sv) $(wildcard verification/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
